/* cclut_pkg.sv */
package cclut_pkg;

  // --------------------
  // table geometry
  // --------------------

  // comparator code bits, 16 codes per pattern
  localparam int comp_code_w = 4;

  // one region per enabled pattern id
  localparam int n_pid = 5;
  localparam int pid_first = 6;

  // pattern ids 6..A on, rest blank
  localparam logic [15:0] pat_en = 16'b0000_0111_1100_0000;

  // address is region index then code
  localparam int lut_addr_w = 7;
  localparam int region_w = lut_addr_w - comp_code_w;
  localparam int lut_depth = 80;

  // --------------------
  // table word
  // --------------------

  localparam int lut_data_w = 9;
  localparam int offs_w = 4;
  localparam int bend_w = 5;
  // bend minus the left/right bit
  localparam int slope_w = bend_w - 1;

  // offset code for no shift, see offset table: 7 -> 0 eighth-strips
  localparam logic [offs_w-1:0] offs_centre = 4'd7;

  // raw view for the memory, fields view for the channel
  typedef union packed {
    logic [lut_data_w-1:0] raw;
    struct packed {
      logic [offs_w-1:0]  offs;
      logic               lr;
      logic [slope_w-1:0] slope;
    } fields;
  } lut_word_u;

endpackage

/* clct_pkg.sv */
package clct_pkg;

  // --------------------
  // pattern word
  // --------------------

  // pid in the low bits
  localparam int pid_w = 4;
  // hit count above the pid
  localparam int hit_w = 3;
  localparam int pat_w = pid_w + hit_w;

  // --------------------
  // positions
  // --------------------

  // key half-strip across the chamber
  localparam int key_hs_w = 8;

  // eighth-strip units, 4 per half-strip
  localparam int pos_w = 10;
  localparam int pos_max = 1023;

  // centre of a half-strip in eighth-strip units
  // default output sits at n+0.5 half-strips
  localparam int hs_centre = 2;

endpackage

/* cclut_lut.sv */
`timescale 1ns/1ps

module cclut_lut (
  input  logic                             clock,
  input  logic                             rd_en,
  input  logic [cclut_pkg::lut_addr_w-1:0] rd_addr,
  output cclut_pkg::lut_word_u             rd_data
);

  import cclut_pkg::*;

  // --------------------
  // storage
  // --------------------

  // five regions of 16 words, pid 6 first
  logic [lut_data_w-1:0] mem [0:lut_depth-1];

  initial begin
    $readmemh("cclut_rom.mem", mem);
  end

  // --------------------
  // region select
  // --------------------

  // upper address bits pick the pattern region
  logic [region_w-1:0] region;
  logic                region_on;

  assign region = rd_addr[lut_addr_w-1 -: region_w];

  always_comb begin
    region_on = 1'b0;
    // addresses past the last region read as blank
    if (int'(region) < n_pid) begin
      region_on = pat_en[pid_first + int'(region)];
    end
  end

  // --------------------
  // registered read
  // --------------------

  // data one cycle after rd_en, held otherwise
  always_ff @(posedge clock) begin
    if (rd_en) begin
      if (region_on) begin
        rd_data.raw <= mem[rd_addr];
      end else begin
        // disabled region gives a zero word
        rd_data.raw <= '0;
      end
    end
  end

endmodule

/* lut_arbiter.sv */
`timescale 1ns/1ps

module lut_arbiter (
  input  logic                             clock,
  input  logic                             rst,
  input  logic                             req0,
  input  logic                             req1,
  input  logic [cclut_pkg::lut_addr_w-1:0] addr0,
  input  logic [cclut_pkg::lut_addr_w-1:0] addr1,
  input  logic                             valid0,
  input  logic                             valid1,
  output logic                             ack0,
  output logic                             ack1,
  output cclut_pkg::lut_word_u             data0,
  output cclut_pkg::lut_word_u             data1,
  output logic                             rd_en,
  output logic [cclut_pkg::lut_addr_w-1:0] rd_addr,
  input  cclut_pkg::lut_word_u             rd_data
);

  import cclut_pkg::*;

  // busy: a channel holds the grant
  // rd_done: the read is back, ack is up
  logic busy;
  logic rd_done;
  // granted channel, also the last one served
  logic gnt;
  // read was done, not skipped
  logic hit_q;

  logic req_sel;
  logic valid_sel;

  assign req_sel = gnt ? req1 : req0;
  assign valid_sel = gnt ? valid1 : valid0;

  // --------------------
  // grant FSM
  // --------------------

  always_ff @(posedge clock) begin
    if (rst) begin
      busy <= 1'b0;
      rd_done <= 1'b0;
      gnt <= 1'b0;
      hit_q <= 1'b0;
    end else if (!busy) begin
      if (req0 || req1) begin
        busy <= 1'b1;
        // both pending, take the one not served last
        if (req0 && req1) begin
          gnt <= ~gnt;
        end else begin
          gnt <= req1;
        end
      end
    end else if (!rd_done) begin
      // read cycle, table answers on this edge
      rd_done <= 1'b1;
      hit_q <= valid_sel;
    end else if (!req_sel) begin
      // channel let go, free the table
      busy <= 1'b0;
      rd_done <= 1'b0;
    end
  end

  // --------------------
  // table side
  // --------------------

  // skip the read for a blank pid
  assign rd_en = busy && !rd_done && valid_sel;
  assign rd_addr = gnt ? addr1 : addr0;

  // --------------------
  // channel side
  // --------------------

  assign ack0 = busy && rd_done && !gnt;
  assign ack1 = busy && rd_done && gnt;

  // table output is stable while the grant is held
  assign data0 = (ack0 && hit_q) ? rd_data : '0;
  assign data1 = (ack1 && hit_q) ? rd_data : '0;

endmodule

/* clct_channel.sv */
`timescale 1ns/1ps

module clct_channel (
  input  logic                             clock,
  input  logic                             rst,
  // input handshake
  input  logic                             in_req,
  output logic                             in_ack,
  input  logic [clct_pkg::pat_w-1:0]       pat,
  input  logic [cclut_pkg::comp_code_w-1:0] code,
  input  logic [clct_pkg::key_hs_w-1:0]    key_hs,
  // table request
  output logic                             lut_req,
  output logic [cclut_pkg::lut_addr_w-1:0] lut_addr,
  output logic                             lut_valid,
  input  logic                             lut_ack,
  input  cclut_pkg::lut_word_u             lut_data,
  // output handshake
  output logic                             out_req,
  output logic [clct_pkg::pos_w-1:0]       pos,
  output logic [cclut_pkg::bend_w-1:0]     bend,
  input  logic                             out_ack
);

  import cclut_pkg::*;
  import clct_pkg::*;

  // captured item
  logic [pid_w-1:0]       pid_q;
  logic [comp_code_w-1:0] code_q;
  logic [key_hs_w-1:0]    key_q;

  // input side still open
  logic in_pend;
  // out_ack seen, waiting for it to fall
  logic out_wait;

  logic idle;
  logic accept;
  logic word_in;

  // --------------------
  // pid decode
  // --------------------

  logic                pid_ok;
  logic [region_w-1:0] region;

  // inside 6..A and switched on
  assign pid_ok = (pid_q >= pid_first) && (pid_q < pid_first + n_pid) && pat_en[pid_q];
  assign region = region_w'(pid_q - pid_w'(pid_first));

  // region index times 16 plus code
  assign lut_addr = pid_ok ? {region, code_q} : '0;
  assign lut_valid = pid_ok;

  // --------------------
  // position refinement
  // --------------------

  // two spare bits, sign and overflow
  logic signed [pos_w+1:0] pos_sum;
  logic [pos_w-1:0]        pos_next;

  // key*4 + centre + offset - 7, in eighth strips
  assign pos_sum = $signed((pos_w+2)'({key_q, 2'b00}))
                 + $signed((pos_w+2)'(hs_centre))
                 + $signed((pos_w+2)'(lut_data.fields.offs))
                 - $signed((pos_w+2)'(offs_centre));

  always_comb begin
    // clamp to the chamber edges
    if (pos_sum < 0) begin
      pos_next = '0;
    end else if (pos_sum > $signed((pos_w+2)'(pos_max))) begin
      pos_next = pos_w'(pos_max);
    end else begin
      pos_next = pos_sum[pos_w-1:0];
    end
  end

  // --------------------
  // handshakes
  // --------------------

  assign idle = !in_pend && !lut_req && !out_req && !out_wait;
  // new item only once the previous one is fully closed
  assign accept = idle && in_req;
  assign word_in = lut_req && lut_ack;

  always_ff @(posedge clock) begin
    if (rst) begin
      in_ack <= 1'b0;
      in_pend <= 1'b0;
      lut_req <= 1'b0;
      out_req <= 1'b0;
      out_wait <= 1'b0;
    end else begin
      if (accept) begin
        in_pend <= 1'b1;
        lut_req <= 1'b1;
      end
      // word back, present the result
      if (word_in) begin
        lut_req <= 1'b0;
        out_req <= 1'b1;
      end
      if (out_req && out_ack) begin
        out_req <= 1'b0;
        out_wait <= 1'b1;
      end
      if (out_wait && !out_ack) begin
        out_wait <= 1'b0;
      end
      // in_ack follows once out_req has risen
      if (in_ack && !in_req) begin
        in_ack <= 1'b0;
        in_pend <= 1'b0;
      end else if (in_pend && !in_ack && (out_req || out_wait)) begin
        in_ack <= 1'b1;
      end
    end
  end

  // payload
  always_ff @(posedge clock) begin
    if (accept) begin
      // hit count not needed here
      pid_q <= pat[pid_w-1:0];
      code_q <= code;
      key_q <= key_hs;
    end
    if (word_in) begin
      pos <= pos_next;
      // left/right bit over the slope
      bend <= {lut_data.fields.lr, lut_data.fields.slope};
    end
  end

endmodule

/* clct_lookup_top.sv */
`timescale 1ns/1ps

module clct_lookup_top (
  input  logic                              clock,
  input  logic                              rst,
  // --------------------
  // channel 0, best
  // --------------------
  input  logic                              in_req0,
  output logic                              in_ack0,
  input  logic [clct_pkg::pat_w-1:0]        pat0,
  input  logic [cclut_pkg::comp_code_w-1:0] code0,
  input  logic [clct_pkg::key_hs_w-1:0]     key_hs0,
  output logic                              out_req0,
  input  logic                              out_ack0,
  output logic [clct_pkg::pos_w-1:0]        pos0,
  output logic [cclut_pkg::bend_w-1:0]      bend0,
  // --------------------
  // channel 1, second best
  // --------------------
  input  logic                              in_req1,
  output logic                              in_ack1,
  input  logic [clct_pkg::pat_w-1:0]        pat1,
  input  logic [cclut_pkg::comp_code_w-1:0] code1,
  input  logic [clct_pkg::key_hs_w-1:0]     key_hs1,
  output logic                              out_req1,
  input  logic                              out_ack1,
  output logic [clct_pkg::pos_w-1:0]        pos1,
  output logic [cclut_pkg::bend_w-1:0]      bend1
);

  import cclut_pkg::*;

  // channel to arbiter
  logic                  lut_req0, lut_req1;
  logic [lut_addr_w-1:0] lut_addr0, lut_addr1;
  logic                  lut_valid0, lut_valid1;
  logic                  lut_ack0, lut_ack1;
  lut_word_u             lut_data0, lut_data1;

  // arbiter to table
  logic                  rd_en;
  logic [lut_addr_w-1:0] rd_addr;
  lut_word_u             rd_data;

  clct_channel clct_channel0_i (
    .clock(clock), .rst(rst),
    .in_req(in_req0), .in_ack(in_ack0), .pat(pat0), .code(code0), .key_hs(key_hs0),
    .lut_req(lut_req0), .lut_addr(lut_addr0), .lut_valid(lut_valid0),
    .lut_ack(lut_ack0), .lut_data(lut_data0),
    .out_req(out_req0), .pos(pos0), .bend(bend0), .out_ack(out_ack0)
  );

  clct_channel clct_channel1_i (
    .clock(clock), .rst(rst),
    .in_req(in_req1), .in_ack(in_ack1), .pat(pat1), .code(code1), .key_hs(key_hs1),
    .lut_req(lut_req1), .lut_addr(lut_addr1), .lut_valid(lut_valid1),
    .lut_ack(lut_ack1), .lut_data(lut_data1),
    .out_req(out_req1), .pos(pos1), .bend(bend1), .out_ack(out_ack1)
  );

  // one table shared round robin
  lut_arbiter lut_arbiter_i (
    .clock(clock), .rst(rst),
    .req0(lut_req0), .req1(lut_req1), .addr0(lut_addr0), .addr1(lut_addr1),
    .valid0(lut_valid0), .valid1(lut_valid1), .ack0(lut_ack0), .ack1(lut_ack1),
    .data0(lut_data0), .data1(lut_data1),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  cclut_lut cclut_lut_i (
    .clock(clock), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

endmodule

/* tb_clct_lookup.sv */
`timescale 1ns/1ps

module tb_clct_lookup;

  import cclut_pkg::*;
  import clct_pkg::*;

  // pid classes for random items
  localparam int kind_on = 0;
  localparam int kind_blank = 1;
  localparam int kind_any = 2;
  // signals a wait can watch
  localparam int sig_in_ack = 0;
  localparam int sig_out_req = 1;
  localparam int timeout_cycles = 100;

  logic clock;
  logic rst;
  logic in_req0, in_ack0, out_req0, out_ack0;
  logic in_req1, in_ack1, out_req1, out_ack1;
  logic [pat_w-1:0] pat0, pat1;
  logic [comp_code_w-1:0] code0, code1;
  logic [key_hs_w-1:0] key_hs0, key_hs1;
  logic [pos_w-1:0] pos0, pos1;
  logic [bend_w-1:0] bend0, bend1;

  // reference copy of the table
  logic [lut_data_w-1:0] rom [0:lut_depth-1];
  // expected {pos, bend} per channel, in order
  logic [pos_w+bend_w-1:0] exp0[$];
  logic [pos_w+bend_w-1:0] exp1[$];
  int unsigned lcg_state = 66;

  clct_lookup_top clct_lookup_top_i (
    .clock(clock), .rst(rst),
    .in_req0(in_req0), .in_ack0(in_ack0), .pat0(pat0), .code0(code0), .key_hs0(key_hs0),
    .out_req0(out_req0), .out_ack0(out_ack0), .pos0(pos0), .bend0(bend0),
    .in_req1(in_req1), .in_ack1(in_ack1), .pat1(pat1), .code1(code1), .key_hs1(key_hs1),
    .out_req1(out_req1), .out_ack1(out_ack1), .pos1(pos1), .bend1(bend1)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    $readmemh("cclut_rom.mem", rom);
  end

  // --------------------
  // helpers
  // --------------------

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // upper bits, low ones cycle too fast
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  function automatic logic [pid_w-1:0] pick_pid(input int kind);
    int r;
    r = int'(lcg_next() % 32'd16);
    case (kind)
      kind_on: begin
        r = 6 + (r % 5);
      end
      kind_blank: begin
        // 0..5 and B..F
        r = r % 11;
        if (r >= 6) begin
          r = r + 5;
        end
      end
      default: begin
      end
    endcase
    return pid_w'(r);
  endfunction

  // expected position and bend from the table rule
  function automatic logic [pos_w+bend_w-1:0] ref_result(input logic [pat_w-1:0] pat,
                                                         input logic [comp_code_w-1:0] code,
                                                         input logic [key_hs_w-1:0] key);
    int pid;
    int offs;
    int p;
    logic [lut_data_w-1:0] word;
    pid = int'(pat[pid_w-1:0]);
    // blank pid reads as zero
    word = '0;
    if (pid >= 6 && pid <= 10 && pat_en[pid]) begin
      word = rom[(pid - 6) * 16 + int'(code)];
    end
    offs = int'(word[8:5]);
    p = int'(key) * 4 + hs_centre + offs - int'(offs_centre);
    if (p < 0) begin
      p = 0;
    end
    if (p > pos_max) begin
      p = pos_max;
    end
    return {pos_w'(p), word[4:0]};
  endfunction

  function automatic logic sig_of(input int ch, input int sel);
    if (sel == sig_in_ack) begin
      return (ch == 0) ? in_ack0 : in_ack1;
    end
    return (ch == 0) ? out_req0 : out_req1;
  endfunction

  // any handshake output of either channel not low
  function automatic logic handshake_up();
    return (in_ack0 !== 1'b0) || (in_ack1 !== 1'b0)
        || (out_req0 !== 1'b0) || (out_req1 !== 1'b0);
  endfunction

  // sample on falling edges until the level shows up
  task automatic wait_for(input int ch, input int sel, input logic level, input string what);
    int cnt;
    cnt = 0;
    do begin
      @(negedge clock);
      cnt++;
    end while (sig_of(ch, sel) !== level && cnt < timeout_cycles);
    if (sig_of(ch, sel) !== level) begin
      $display("Timeout on channel %0d while waiting for %s", ch, what);
      $display("Test failed");
      $fatal(1, "wait timed out");
    end
  endtask

  // --------------------
  // compare
  // --------------------

  task automatic check_pos(input int ch, input logic [pos_w-1:0] got,
                           input logic [pos_w-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: channel %0d pos %0d, expected %0d", $time, ch, got, exp);
      $display("Test failed");
      $fatal(1, "position mismatch");
    end
  endtask

  task automatic check_bend(input int ch, input logic [bend_w-1:0] got,
                            input logic [bend_w-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: channel %0d bend %h, expected %h", $time, ch, got, exp);
      $display("Test failed");
      $fatal(1, "bend mismatch");
    end
  endtask

  // --------------------
  // input side
  // --------------------

  task automatic present_item(input int ch, input logic [pat_w-1:0] pat,
                              input logic [comp_code_w-1:0] code,
                              input logic [key_hs_w-1:0] key);
    @(negedge clock);
    if (ch == 0) begin
      pat0 = pat;
      code0 = code;
      key_hs0 = key;
      in_req0 = 1'b1;
      exp0.push_back(ref_result(pat, code, key));
    end else begin
      pat1 = pat;
      code1 = code;
      key_hs1 = key;
      in_req1 = 1'b1;
      exp1.push_back(ref_result(pat, code, key));
    end
  endtask

  // close the four-phase input handshake
  task automatic complete_item(input int ch);
    wait_for(ch, sig_in_ack, 1'b1, "in_ack to rise");
    if (ch == 0) begin
      in_req0 = 1'b0;
    end else begin
      in_req1 = 1'b0;
    end
    wait_for(ch, sig_in_ack, 1'b0, "in_ack to fall");
  endtask

  task automatic send_item(input int ch, input logic [pat_w-1:0] pat,
                           input logic [comp_code_w-1:0] code,
                           input logic [key_hs_w-1:0] key);
    present_item(ch, pat, code, key);
    complete_item(ch);
  endtask

  task automatic send_random(input int ch, input int kind);
    logic [pat_w-1:0] pat;
    logic [comp_code_w-1:0] code;
    logic [key_hs_w-1:0] key;
    pat = {hit_w'(lcg_next()), pick_pid(kind)};
    code = comp_code_w'(lcg_next());
    key = key_hs_w'(lcg_next());
    send_item(ch, pat, code, key);
  endtask

  // --------------------
  // output side
  // --------------------

  task automatic receive_items(input int ch, input int n);
    logic [pos_w+bend_w-1:0] exp;
    for (int i = 0; i < n; i++) begin
      wait_for(ch, sig_out_req, 1'b1, "out_req to rise");
      if ((ch == 0 && exp0.size() == 0) || (ch == 1 && exp1.size() == 0)) begin
        $display("Channel %0d raised out_req with no item outstanding", ch);
        $display("Test failed");
        $fatal(1, "unexpected output");
      end
      exp = (ch == 0) ? exp0.pop_front() : exp1.pop_front();
      check_pos(ch, (ch == 0) ? pos0 : pos1, exp[pos_w+bend_w-1:bend_w]);
      check_bend(ch, (ch == 0) ? bend0 : bend1, exp[bend_w-1:0]);
      if (ch == 0) begin
        out_ack0 = 1'b1;
      end else begin
        out_ack1 = 1'b1;
      end
      wait_for(ch, sig_out_req, 1'b0, "out_req to fall");
      if (ch == 0) begin
        out_ack0 = 1'b0;
      end else begin
        out_ack1 = 1'b0;
      end
    end
  endtask

  task automatic run_items(input int ch, input int n, input int kind);
    fork
      begin
        for (int i = 0; i < n; i++) begin
          send_random(ch, kind);
        end
      end
      receive_items(ch, n);
    join
  endtask

  // --------------------
  // sequence
  // --------------------

  initial begin
    int quiet_cycles;
    rst = 1'b1;
    in_req0 = 1'b0;
    in_req1 = 1'b0;
    out_ack0 = 1'b0;
    out_ack1 = 1'b0;
    pat0 = '0;
    pat1 = '0;
    code0 = '0;
    code1 = '0;
    key_hs0 = '0;
    key_hs1 = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;

    // idle after reset
    repeat (5) begin
      @(negedge clock);
      if (in_ack0 !== 1'b0 || in_ack1 !== 1'b0 || out_req0 !== 1'b0 || out_req1 !== 1'b0) begin
        $display("A handshake output is not low after reset");
        $display("Test failed");
        $fatal(1, "reset state");
      end
    end

    // one channel at a time
    run_items(0, 20, kind_on);
    run_items(1, 20, kind_on);
    run_items(0, 10, kind_blank);
    run_items(1, 10, kind_blank);

    // code 0 has offset 0, code 15 has offset 15
    fork
      begin
        send_item(0, {3'd5, 4'd6}, 4'd0, 8'd0);
        send_item(0, {3'd5, 4'd6}, 4'd15, 8'd255);
      end
      receive_items(0, 2);
      begin
        send_item(1, {3'd3, 4'd8}, 4'd0, 8'd0);
        send_item(1, {3'd3, 4'd10}, 4'd15, 8'd255);
      end
      receive_items(1, 2);
    join

    // both channels loaded together
    fork
      run_items(0, 40, kind_on);
      run_items(1, 40, kind_any);
    join

    // channel 1 stalled at its output
    fork
      begin
        send_item(1, {3'd1, 4'd7}, 4'd3, 8'd100);
        present_item(1, {3'd2, 4'd9}, 4'd12, 8'd40);
        repeat (40) begin
          @(negedge clock);
          if (in_ack1 !== 1'b0) begin
            $display("Channel 1 took a new item while its output was stalled");
            $display("Test failed");
            $fatal(1, "back-pressure");
          end
        end
      end
      run_items(0, 6, kind_on);
    join
    // release channel 1, both held items drain
    fork
      complete_item(1);
      receive_items(1, 2);
    join

    // drained, nothing more may come out
    quiet_cycles = 0;
    do begin
      @(negedge clock);
      quiet_cycles++;
    end while (quiet_cycles < 10 && !handshake_up());

    if (handshake_up()) begin
      $display("A channel raised in_ack or out_req after the last item");
      $display("Test failed");
      $fatal(1, "stray handshake");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* cclut_rom.mem */
// one 9-bit word per line: offset [8:5], left/right [4], slope [3:0]
// 16 codes per pattern id, pid 6 first, pid A last
000
037
04E
075
08C
0B3
0CA
0F1
108
13F
146
17D
184
1BB
1C2
1F9
013
02A
051
068
09F
0A6
0DD
0E4
11B
122
159
160
197
1AE
1D5
1EC
006
03D
044
07B
082
0B9
0C0
0F7
10E
135
14C
173
18A
1B1
1C8
1FF
019
020
057
06E
095
0AC
0D3
0EA
111
128
15F
166
19D
1A4
1DB
1E2
00C
033
04A
071
088
0BF
0C6
0FD
104
13B
142
179
180
1B7
1CE
1F5

/* all.f */
cclut_pkg.sv
clct_pkg.sv
cclut_lut.sv
lut_arbiter.sv
clct_channel.sv
clct_lookup_top.sv
tb_clct_lookup.sv

/* run.sh */
#!/bin/sh
# build and run from the project root so the table file is found
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_clct_lookup \
  -o tb_clct_lookup \
  && ./obj_dir/tb_clct_lookup \
  || { echo "simulation did not pass"; exit 1; }
